// File: design/bp_pkg.sv
// branch predictor package, shared widths, table index layout and state encodings
package bp_pkg;

    // address and table geometry
    localparam int pc_width     = 32;
    localparam int index_width  = 8;
    localparam int index_lsb    = 3;    // skip the bundle offset
    localparam int index_msb    = index_lsb + index_width - 1;
    localparam int table_depth  = 1 << index_width;
    localparam int bundle_bytes = 8;

    // predecoder branch type
    localparam logic [1:0] btype_none   = 2'b00;
    localparam logic [1:0] btype_uncond = 2'b01;
    localparam logic [1:0] btype_rel    = 2'b10;
    localparam logic [1:0] btype_ind    = 2'b11;

    // 2-bit direction counters, bit 0 set means not taken
    localparam logic [1:0] ctr_strong_taken = 2'b00;
    localparam logic [1:0] ctr_strong_not   = 2'b01;
    localparam logic [1:0] ctr_weak_taken   = 2'b10;
    localparam logic [1:0] ctr_weak_not     = 2'b11;

    // strategy chooser
    localparam logic [1:0] sel_static   = 2'b00;    // static not taken
    localparam logic [1:0] sel_easy     = 2'b01;
    localparam logic [1:0] sel_hard     = 2'b10;
    localparam logic [1:0] sel_reserved = 2'b11;    // always taken, never chosen

    // hit score, bit 1 set favours the easy counter
    localparam logic [1:0] score_low    = 2'b00;
    localparam logic [1:0] score_miss   = 2'b01;
    localparam logic [1:0] score_recov  = 2'b10;
    localparam logic [1:0] score_high   = 2'b11;

endpackage

// File: design/target_ram.sv
// target table storage, asynchronous read port and one synchronous write port
`timescale 1ns/1ns

module target_ram import bp_pkg::*; #(
    parameter int depth      = table_depth,
    parameter int data_width = pc_width
) (
    input  logic                   clk,
    input  logic [index_width-1:0] rd_addr,
    output logic [data_width-1:0]  rd_data,
    input  logic [index_width-1:0] wr_addr,
    input  logic [data_width-1:0]  wr_data,
    input  logic                   wr_en
);

    logic [data_width-1:0] mem [depth];

    // old data on a same-cycle read, new data visible after the edge
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

// File: design/direction_predictor.sv
// global direction predictor, easy and hard 2-bit counters picked by a hit score
`timescale 1ns/1ns

module direction_predictor import bp_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic upd_valid,
    input  logic upd_taken,
    input  logic dir_fail,
    output logic pred_taken
);

    logic [1:0] easy_ctr;
    logic [1:0] easy_next;
    logic [1:0] hard_ctr;
    logic [1:0] hard_next;
    logic [1:0] score;
    logic [1:0] score_next;
    logic [1:0] chooser;
    logic [1:0] chooser_next;
    logic       seen_upd;   // set once the first update has arrived
    logic       hit;

    assign hit = !dir_fail;

    // easy counter jumps straight to strong on a repeat, else to weak
    always_comb begin
        if (upd_taken) begin
            case (easy_ctr)
                ctr_strong_taken, ctr_weak_taken: easy_next = ctr_strong_taken;
                default:                          easy_next = ctr_weak_taken;
            endcase
        end else begin
            case (easy_ctr)
                ctr_strong_not, ctr_weak_not: easy_next = ctr_strong_not;
                default:                      easy_next = ctr_weak_not;
            endcase
        end
    end

    // hard counter, saturating with hysteresis
    always_comb begin
        case (hard_ctr)
            ctr_strong_taken: hard_next = upd_taken ? ctr_strong_taken : ctr_weak_taken;
            ctr_weak_taken:   hard_next = upd_taken ? ctr_strong_taken : ctr_weak_not;
            ctr_weak_not:     hard_next = upd_taken ? ctr_weak_taken   : ctr_strong_not;
            default:          hard_next = upd_taken ? ctr_weak_not     : ctr_strong_not;
        endcase
    end

    always_comb begin
        case (score)
            score_low:   score_next = hit ? score_low  : score_miss;
            score_miss:  score_next = hit ? score_low  : score_recov;
            score_recov: score_next = hit ? score_high : score_miss;
            default:     score_next = hit ? score_high : score_recov;
        endcase
    end

    // chooser follows the score one edge behind
    assign chooser_next = score[1] ? sel_easy : sel_hard;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            easy_ctr <= ctr_weak_taken;
            hard_ctr <= ctr_weak_taken;
            score    <= score_low;
        end else if (upd_valid) begin
            easy_ctr <= easy_next;
            hard_ctr <= hard_next;
            score    <= score_next;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seen_upd <= 1'b0;
            chooser  <= sel_static;
        end else begin
            if (upd_valid) begin
                seen_upd <= 1'b1;
            end
            // static until the first update, then reloaded every edge
            if (upd_valid || seen_upd) begin
                chooser <= chooser_next;
            end
        end
    end

    always_comb begin
        case (chooser)
            sel_easy: pred_taken = !easy_ctr[0];
            sel_hard: pred_taken = !hard_ctr[0];
            sel_reserved: pred_taken = 1'b1;
            default: pred_taken = 1'b0;   // sel_static
        endcase
    end

endmodule

// File: design/target_buffer.sv
// branch target buffer, valid bits over the target table and the predicted fetch address
`timescale 1ns/1ns

module target_buffer import bp_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic [pc_width-1:0] fetch_pc,
    input  logic [1:0]          inst_btype,
    input  logic                upd_valid,
    input  logic [pc_width-1:0] upd_pc,
    input  logic [pc_width-1:0] upd_target,
    input  logic                upd_taken,
    input  logic                addr_fail,
    output logic [pc_width-1:0] pred_pc
);

    logic [table_depth-1:0] valid;
    logic [index_width-1:0] rd_addr;
    logic [index_width-1:0] wr_addr;
    logic [pc_width-1:0]    wr_data;
    logic [pc_width-1:0]    rd_data;
    logic                   wr_en;
    logic                   clr_en;
    logic [pc_width-1:0]    seq_pc;

    assign rd_addr = fetch_pc[index_msb:index_lsb];
    assign wr_addr = upd_pc[index_msb:index_lsb];
    assign wr_data = upd_target;

    // only a taken branch that went to the wrong place trains the table
    assign wr_en  = upd_valid && upd_taken && addr_fail;
    assign clr_en = (inst_btype == btype_none) && !wr_en;

    assign seq_pc  = fetch_pc + pc_width'(bundle_bytes);
    assign pred_pc = valid[rd_addr] ? rd_data : seq_pc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_addr] <= 1'b1;
        end else if (clr_en) begin
            valid[rd_addr] <= 1'b0;   // predecoder says no branch here
        end
    end

    target_ram #(
        .depth      (table_depth),
        .data_width (pc_width)
    ) u_target_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

endmodule

// File: design/branch_predictor.sv
// branch predictor top, target buffer for the address and global direction predictor
`timescale 1ns/1ns

module branch_predictor import bp_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    // fetch side
    input  logic [pc_width-1:0] fetch_pc,
    input  logic [1:0]          inst_btype,
    // resolved branch from execute
    input  logic                upd_valid,
    input  logic [pc_width-1:0] upd_pc,
    input  logic [pc_width-1:0] upd_target,
    input  logic                upd_taken,
    input  logic                dir_fail,
    input  logic                addr_fail,
    // prediction, same cycle as fetch_pc
    output logic [pc_width-1:0] pred_pc,
    output logic                pred_taken
);

    target_buffer u_target_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .inst_btype (inst_btype),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd_taken  (upd_taken),
        .addr_fail  (addr_fail),
        .pred_pc    (pred_pc)
    );

    direction_predictor u_direction_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .upd_valid  (upd_valid),
        .upd_taken  (upd_taken),
        .dir_fail   (dir_fail),
        .pred_taken (pred_taken)
    );

endmodule

// File: testbench/bp_props.sv
// bound assertions for the branch predictor, reset state, valid bits and chooser
`timescale 1ns/1ns

module bp_props import bp_pkg::*; (
    input logic                   clk,
    input logic                   rstn,
    input logic                   check_table,
    input logic                   check_dir,
    input logic                   wr_en,
    input logic [index_width-1:0] wr_addr,
    input logic [table_depth-1:0] valid,
    input logic                   upd_valid,
    input logic [1:0]             chooser,
    input logic                   pred_taken
);

    logic seen_upd;   // first update has been sampled

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seen_upd <= 1'b0;
        end else if (upd_valid) begin
            seen_upd <= 1'b1;
        end
    end

    // static not taken in the first cycle out of reset
    assert property (@(posedge clk) disable iff (!check_dir)
        $rose(rstn) |-> !pred_taken)
        else $error("pred_taken high in the first cycle after reset");

    assert property (@(posedge clk) disable iff (!rstn || !check_table)
        wr_en |=> valid[$past(wr_addr)])
        else $error("written table entry not valid after the write edge");

    assert property (@(posedge clk) disable iff (!rstn || !check_dir)
        seen_upd |-> chooser != sel_static)
        else $error("chooser back at static after an update");

endmodule

bind target_buffer bp_props u_table_props (
    .clk         (clk),
    .rstn        (rstn),
    .check_table (1'b1),
    .check_dir   (1'b0),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .valid       (valid),
    .upd_valid   (upd_valid),
    .chooser     (sel_static),
    .pred_taken  (1'b0)
);

bind direction_predictor bp_props u_dir_props (
    .clk         (clk),
    .rstn        (rstn),
    .check_table (1'b0),
    .check_dir   (1'b1),
    .wr_en       (1'b0),
    .wr_addr     ('0),
    .valid       ('0),
    .upd_valid   (upd_valid),
    .chooser     (chooser),
    .pred_taken  (pred_taken)
);

// File: testbench/tb_branch_predictor.sv
// testbench for the branch predictor, reference model and directed tests
`timescale 1ns/1ns

module tb_branch_predictor import bp_pkg::*; ();

    localparam int reset_cycles = 10;
    localparam int wait_limit   = 40;

    logic                clk = 1'b0;
    logic                rstn;
    logic [pc_width-1:0] fetch_pc;
    logic [1:0]          inst_btype;
    logic                upd_valid;
    logic [pc_width-1:0] upd_pc;
    logic [pc_width-1:0] upd_target;
    logic                upd_taken;
    logic                dir_fail;
    logic                addr_fail;
    logic [pc_width-1:0] pred_pc;
    logic                pred_taken;

    // reference model
    logic                m_valid [table_depth];
    logic [pc_width-1:0] m_target [table_depth];
    logic [1:0]          m_easy;
    logic [1:0]          m_hard;
    logic [1:0]          m_score;
    logic [1:0]          m_chooser;
    logic                m_seen;

    // extra expectations for the next tick
    logic                want_pc_en;
    logic [pc_width-1:0] want_pc;
    logic                want_taken_en;
    logic                want_taken;

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    branch_predictor dut (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .inst_btype (inst_btype),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd_taken  (upd_taken),
        .dir_fail   (dir_fail),
        .addr_fail  (addr_fail),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi = rng_state;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], rng_state[31:16]};   // upper halves only
    endfunction

    function automatic logic [pc_width-1:0] rand_target();
        logic [31:0] r;
        r = next_rand();
        return {r[31:3], 3'b000};
    endfunction

    function automatic logic [pc_width-1:0] pc_at_index(input logic [index_width-1:0] idx);
        logic [31:0] r;
        r = next_rand();
        r[index_msb:index_lsb] = idx;
        r[2:0] = 3'b000;
        return r;
    endfunction

    function automatic logic [index_width-1:0] free_index();
        logic [31:0]            r;
        logic [index_width-1:0] idx;
        idx = '0;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            idx = r[index_width-1:0];
            if (!m_valid[idx]) break;
        end
        return idx;
    endfunction

    function automatic logic [1:0] easy_step(input logic [1:0] ctr, input logic taken);
        // jumps to strong when the outcome agrees with the counter side
        if (taken) return ctr[0] ? ctr_weak_taken : ctr_strong_taken;
        return ctr[0] ? ctr_strong_not : ctr_weak_not;
    endfunction

    function automatic logic [1:0] hard_step(input logic [1:0] ctr, input logic taken);
        int level;
        case (ctr)
            ctr_strong_not: level = 0;
            ctr_weak_not:   level = 1;
            ctr_weak_taken: level = 2;
            default:        level = 3;
        endcase
        if (taken && level < 3) level++;
        else if (!taken && level > 0) level--;
        case (level)
            0:       return ctr_strong_not;
            1:       return ctr_weak_not;
            2:       return ctr_weak_taken;
            default: return ctr_strong_taken;
        endcase
    endfunction

    function automatic logic [1:0] score_step(input logic [1:0] score, input logic hit);
        case (score)
            2'b00:   return hit ? 2'b00 : 2'b01;
            2'b01:   return hit ? 2'b00 : 2'b10;
            2'b10:   return hit ? 2'b11 : 2'b01;
            default: return hit ? 2'b11 : 2'b10;
        endcase
    endfunction

    function automatic logic [pc_width-1:0] model_pc();
        logic [index_width-1:0] idx;
        idx = fetch_pc[index_msb:index_lsb];
        if (m_valid[idx]) return m_target[idx];
        return fetch_pc + pc_width'(bundle_bytes);
    endfunction

    function automatic logic model_taken();
        if (m_chooser == sel_easy) return !m_easy[0];
        if (m_chooser == sel_hard) return !m_hard[0];
        return m_chooser == sel_reserved;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < table_depth; i++) begin
            m_valid[i] = 1'b0;
        end
        m_easy = ctr_weak_taken;
        m_hard = ctr_weak_taken;
        m_score = 2'b00;
        m_chooser = sel_static;
        m_seen = 1'b0;
    endtask

    // one clock edge of the model, same inputs the DUT samples
    task automatic model_edge();
        logic [index_width-1:0] wr_idx;
        logic [index_width-1:0] rd_idx;
        wr_idx = upd_pc[index_msb:index_lsb];
        rd_idx = fetch_pc[index_msb:index_lsb];
        if (upd_valid && upd_taken && addr_fail) begin
            m_valid[wr_idx] = 1'b1;
            m_target[wr_idx] = upd_target;
        end else if (inst_btype == btype_none) begin
            m_valid[rd_idx] = 1'b0;
        end
        if (upd_valid || m_seen) begin
            m_chooser = m_score[1] ? sel_easy : sel_hard;   // score before this edge
        end
        if (upd_valid) begin
            m_seen = 1'b1;
            m_easy = easy_step(m_easy, upd_taken);
            m_hard = hard_step(m_hard, upd_taken);
            m_score = score_step(m_score, !dir_fail);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got,
                     expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic expect_pc(input logic [pc_width-1:0] value);
        want_pc_en = 1'b1;
        want_pc = value;
    endtask

    task automatic expect_taken(input logic value);
        want_taken_en = 1'b1;
        want_taken = value;
    endtask

    // compare in the low phase, then advance model and drive after the edge
    task automatic tick();
        @(negedge clk);
        check_value("pred_pc", pred_pc, model_pc());
        check_value("pred_taken", 32'(pred_taken), 32'(model_taken()));
        if (want_pc_en) check_value("pred_pc", pred_pc, want_pc);
        if (want_taken_en) check_value("pred_taken", 32'(pred_taken), 32'(want_taken));
        want_pc_en = 1'b0;
        want_taken_en = 1'b0;
        @(posedge clk);
        model_edge();
        #1;
    endtask

    task automatic idle();
        upd_valid = 1'b0;
        upd_taken = 1'b0;
        dir_fail = 1'b0;
        addr_fail = 1'b0;
        inst_btype = btype_rel;
    endtask

    task automatic drive_update(input logic [pc_width-1:0] pc, input logic [pc_width-1:0] tgt,
                                input logic taken, input logic dfail, input logic afail);
        upd_valid = 1'b1;
        upd_pc = pc;
        upd_target = tgt;
        upd_taken = taken;
        dir_fail = dfail;
        addr_fail = afail;
    endtask

    task automatic apply_reset();
        int waited;
        rstn = 1'b0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;
        waited = 0;
        while (pred_pc !== fetch_pc + pc_width'(bundle_bytes) && waited < wait_limit) begin
            @(posedge clk);
            model_edge();
            #1;
            waited++;
        end
        if (waited == wait_limit) report_timeout("the predictor to leave reset");
    endtask

    task automatic fetch_after_reset();
        logic [31:0] r;
        repeat (16) begin
            r = next_rand();
            fetch_pc = {r[31:3], 3'b000};
            inst_btype = r[5:4];
            expect_pc(fetch_pc + pc_width'(bundle_bytes));
            expect_taken(1'b0);
            tick();
        end
        idle();
    endtask

    task automatic target_write_and_read();
        logic [index_width-1:0] idx;
        logic [index_width-1:0] other;
        logic [pc_width-1:0]    tgt;
        idx = free_index();
        tgt = rand_target();
        drive_update(pc_at_index(idx), tgt, 1'b1, 1'b0, 1'b1);
        fetch_pc = pc_at_index(idx);
        expect_pc(fetch_pc + pc_width'(bundle_bytes));   // old entry this cycle
        tick();
        idle();
        repeat (4) begin
            fetch_pc = pc_at_index(idx);
            expect_pc(tgt);
            tick();
        end
        other = free_index();
        fetch_pc = pc_at_index(other);
        expect_pc(fetch_pc + pc_width'(bundle_bytes));
        tick();
    endtask

    task automatic write_block_and_clear();
        logic [index_width-1:0] idx;
        logic [pc_width-1:0]    tgt;
        logic [pc_width-1:0]    tgt_new;
        // no write without addr_fail, nor without taken
        idx = free_index();
        drive_update(pc_at_index(idx), rand_target(), 1'b1, 1'b0, 1'b0);
        tick();
        idle();
        fetch_pc = pc_at_index(idx);
        expect_pc(fetch_pc + pc_width'(bundle_bytes));
        tick();
        idx = free_index();
        drive_update(pc_at_index(idx), rand_target(), 1'b0, 1'b0, 1'b1);
        tick();
        idle();
        fetch_pc = pc_at_index(idx);
        expect_pc(fetch_pc + pc_width'(bundle_bytes));
        tick();
        // predecoder reports no branch
        idx = free_index();
        tgt = rand_target();
        drive_update(pc_at_index(idx), tgt, 1'b1, 1'b0, 1'b1);
        tick();
        idle();
        fetch_pc = pc_at_index(idx);
        inst_btype = btype_none;
        expect_pc(tgt);
        tick();
        inst_btype = btype_rel;
        fetch_pc = pc_at_index(idx);
        expect_pc(fetch_pc + pc_width'(bundle_bytes));
        tick();
        // write and clear together, write wins
        idx = free_index();
        tgt = rand_target();
        drive_update(pc_at_index(idx), tgt, 1'b1, 1'b0, 1'b1);
        tick();
        tgt_new = rand_target();
        drive_update(pc_at_index(idx), tgt_new, 1'b1, 1'b0, 1'b1);
        fetch_pc = pc_at_index(idx);
        inst_btype = btype_none;
        expect_pc(tgt);
        tick();
        idle();
        fetch_pc = pc_at_index(idx);
        expect_pc(tgt_new);
        tick();
    endtask

    task automatic chooser_easy_hard();
        logic [31:0] r;
        int          n;
        // misses lift the score to 10, then hits take it to 11
        n = 0;
        while ((m_score != 2'b11 || m_chooser != sel_easy) && n < wait_limit) begin
            r = next_rand();
            drive_update(r, rand_target(), r[7], !m_score[1], 1'b0);
            tick();
            idle();
            expect_taken(m_chooser == sel_easy ? !m_easy[0] : !m_hard[0]);
            tick();
            n++;
        end
        if (m_score != 2'b11 || m_chooser != sel_easy) begin
            report_timeout("the chooser to select the easy counter");
        end
        // a run of hits keeps the easy counter in charge
        repeat (8) begin
            r = next_rand();
            drive_update(r, rand_target(), r[8], 1'b0, 1'b0);
            tick();
            idle();
            expect_taken(!m_easy[0]);
            tick();
            check_value("chooser", 32'(dut.u_direction_predictor.chooser), 32'(sel_easy));
        end
        // misses pull the score down, then it is held below 10
        n = 0;
        while (m_chooser != sel_hard && n < wait_limit) begin
            r = next_rand();
            drive_update(r, rand_target(), r[9], m_score[1] || m_score == 2'b00, 1'b0);
            tick();
            idle();
            expect_taken(m_chooser == sel_easy ? !m_easy[0] : !m_hard[0]);
            tick();
            n++;
        end
        if (m_chooser != sel_hard) report_timeout("the chooser to select the hard counter");
        repeat (8) begin
            r = next_rand();
            drive_update(r, rand_target(), r[11], m_score == 2'b00, 1'b0);
            tick();
            idle();
            expect_taken(!m_hard[0]);
            tick();
            check_value("chooser", 32'(dut.u_direction_predictor.chooser), 32'(sel_hard));
        end
    endtask

    task automatic random_mix();
        logic [31:0] r;
        repeat (400) begin
            r = next_rand();
            upd_valid = r[0];
            upd_taken = r[1];
            dir_fail = r[2];
            addr_fail = r[3];
            inst_btype = r[5:4];
            upd_pc = pc_at_index({4'b1010, r[11:8]});   // 16 entries, plenty of reuse
            upd_target = rand_target();
            fetch_pc = pc_at_index({4'b1010, r[15:12]});
            tick();
        end
        idle();
        tick();
    endtask

    initial begin
        rstn = 1'b0;
        fetch_pc = '0;
        upd_pc = '0;
        upd_target = '0;
        idle();
        errors = 0;
        checks = 0;
        rng_state = 32'd62747;
        want_pc_en = 1'b0;
        want_pc = '0;
        want_taken_en = 1'b0;
        want_taken = 1'b0;
        apply_reset();
        fetch_after_reset();
        target_write_and_read();
        write_block_and_clear();
        chooser_easy_hard();
        random_mix();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: files.f
design/bp_pkg.sv
design/target_ram.sv
design/direction_predictor.sv
design/target_buffer.sv
design/branch_predictor.sv
testbench/bp_props.sv
testbench/tb_branch_predictor.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_branch_predictor
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := === FAIL ===
PASS_MSG := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
